/* design/gmt_cmd_decode.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module gmt_cmd_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              accept,
    input  gmt_pkg::gmt_req_t req,
    output gmt_pkg::gmt_cmd_t cmd_live,
    output gmt_pkg::gmt_cmd_t cmd
);
    import gmt_pkg::*;

    always_comb begin
        cmd_live = '0;
        case (req.op)
            `GMT_OP_CREATE:    cmd_live.kind = K_CREATE;
            `GMT_OP_DELETE:    cmd_live.kind = K_DELETE;
            `GMT_OP_TRANS_ONE: cmd_live.kind = K_TRANS_ONE;
            `GMT_OP_TRANS_ALL: cmd_live.kind = K_TRANS_ALL;
            `GMT_OP_SCALE:     cmd_live.kind = K_SCALE;
            `GMT_OP_ROT_L:     cmd_live.kind = K_ROT_L;
            `GMT_OP_ROT_R:     cmd_live.kind = K_ROT_R;
            default:           cmd_live.kind = K_NONE;   // reflect, matrix, loadback
        endcase
        cmd_live.pt_sel   = req.code[3:2];
        cmd_live.tx       = req.code[0];
        cmd_live.ty       = req.code[1];
        cmd_live.rot_step = req.code[2:0];
        cmd_live.cen      = (cmd_live.kind == K_SCALE) ||
                            ((cmd_live.kind inside {K_ROT_L, K_ROT_R}) && req.code[3]);
        // ratio = num >> shift
        case (req.code[1:0])
            2'd0:    {cmd_live.scl_num, cmd_live.scl_shift} = {2'd1, 2'd1};
            2'd1:    {cmd_live.scl_num, cmd_live.scl_shift} = {2'd3, 2'd2};
            2'd2:    {cmd_live.scl_num, cmd_live.scl_shift} = {2'd3, 2'd1};
            default: {cmd_live.scl_num, cmd_live.scl_shift} = {2'd2, 2'd0};
        endcase
        cmd_live.offset = req.obj.pts[0].x;   // translate amount rides on vertex 0 x
        cmd_live.slot   = req.slot;
    end

    // CPU may drop its inputs once the command is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (accept) begin
            cmd <= cmd_live;
        end
    end

endmodule

/* design/gmt_consts.svh */
`ifndef GMT_CONSTS_SVH
`define GMT_CONSTS_SVH

// datapath widths
`define GMT_COORD_W 16    // signed pixel coordinate
`define GMT_SLOT_W  5     // object slot number
`define GMT_Q15     15    // fraction bits of the sin/cos table

// CPU opcodes that the unit still serves
`define GMT_OP_CREATE    4'h0
`define GMT_OP_DELETE    4'h1
`define GMT_OP_TRANS_ONE 4'h3
`define GMT_OP_TRANS_ALL 4'h4
`define GMT_OP_SCALE     4'h5
`define GMT_OP_ROT_L     4'h6
`define GMT_OP_ROT_R     4'h7

`endif

/* design/gmt_pkg.sv */
`include "gmt_consts.svh"

package gmt_pkg;

    typedef struct packed {
        logic signed [`GMT_COORD_W-1:0] y;
        logic signed [`GMT_COORD_W-1:0] x;
    } gmt_point_t;

    // video memory image of one object
    typedef struct packed {
        logic [1:0]       shape;    // 0 point, 1 line, 2 triangle, 3 quad
        logic [5:0]       pad;
        logic [7:0]       colour;
        gmt_point_t [3:0] pts;      // point 3 on top
    } gmt_obj_t;

    typedef struct packed {
        logic [3:0]             op;
        logic [3:0]             code;
        logic [`GMT_SLOT_W-1:0] slot;
        gmt_obj_t               obj;
    } gmt_req_t;

    typedef enum logic [2:0] {
        K_NONE, K_CREATE, K_DELETE, K_TRANS_ONE, K_TRANS_ALL, K_SCALE, K_ROT_L, K_ROT_R
    } gmt_kind_t;

    typedef struct packed {
        gmt_kind_t                      kind;
        logic [1:0]                     pt_sel;     // translate-one target
        logic                           tx;
        logic                           ty;
        logic [2:0]                     rot_step;   // multiples of 45 deg
        logic                           cen;        // work about the centroid
        logic [1:0]                     scl_num;
        logic [1:0]                     scl_shift;
        logic signed [`GMT_COORD_W-1:0] offset;
        logic [`GMT_SLOT_W-1:0]         slot;
        logic                           spare;
    } gmt_cmd_t;

    typedef struct packed {
        logic signed [`GMT_COORD_W-1:0] c11;
        logic signed [`GMT_COORD_W-1:0] c12;
        logic signed [`GMT_COORD_W-1:0] c21;
        logic signed [`GMT_COORD_W-1:0] c22;
        logic signed [`GMT_COORD_W-1:0] ox;
        logic signed [`GMT_COORD_W-1:0] oy;
    } gmt_coeff_t;

endpackage

/* design/gmt_sequencer.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module gmt_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  gmt_pkg::gmt_cmd_t      cmd_live,
    input  gmt_pkg::gmt_cmd_t      cmd,
    input  logic [1:0]             obj_type,
    input  logic                   addr_vld,
    input  logic                   obj_mem_full,
    input  logic                   res_vld,
    output logic                   accept,
    output logic                   busy,
    output logic                   crt_obj,
    output logic                   del_obj,
    output logic                   ref_addr,
    output logic                   rd_en,
    output logic                   wr_en,
    output logic [`GMT_SLOT_W-1:0] obj_num_out,
    output logic                   ld_obj,
    output logic                   calc_cen,
    output logic                   issue,
    output logic                   ldback,
    output logic                   writeback,
    output logic [1:0]             point_idx,
    output logic                   coeff_start
);
    import gmt_pkg::*;

    typedef enum logic [3:0] {
        IDLE, WAIT_WR, WAIT_RD, LOAD, CENTROID, COEFF_WAIT, ISSUE, PT_WAIT, WRITEBACK
    } state_t;

    state_t st, nxt_st;
    logic   idle;
    logic   xform_live;
    logic   is_rot;
    logic   last_pt;

    assign idle       = (st == IDLE);
    assign xform_live = cmd_live.kind inside {K_TRANS_ONE, K_TRANS_ALL, K_SCALE, K_ROT_L, K_ROT_R};
    assign is_rot     = cmd.kind inside {K_ROT_L, K_ROT_R};
    assign last_pt    = (point_idx == obj_type);
    assign accept     = go && idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st <= IDLE;
        end else begin
            st <= nxt_st;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            point_idx <= '0;
        end else if (ld_obj) begin
            point_idx <= '0;
        end else if (ldback && !last_pt) begin
            point_idx <= point_idx + 2'd1;
        end
    end

    always_comb begin
        nxt_st      = st;
        busy        = 1'b1;
        crt_obj     = 1'b0;
        del_obj     = 1'b0;
        ref_addr    = 1'b0;
        rd_en       = 1'b0;
        wr_en       = 1'b0;
        ld_obj      = 1'b0;
        calc_cen    = 1'b0;
        issue       = 1'b0;
        ldback      = 1'b0;
        writeback   = 1'b0;
        coeff_start = 1'b0;
        case (st)
            IDLE: begin
                busy = go && (cmd_live.kind != K_NONE);
                if (accept) begin
                    if (cmd_live.kind == K_CREATE && !obj_mem_full) begin
                        crt_obj = 1'b1;
                        nxt_st  = WAIT_WR;
                    end else if (cmd_live.kind == K_DELETE) begin
                        del_obj = 1'b1;     // done in this cycle
                    end else if (xform_live) begin
                        ref_addr = 1'b1;
                        nxt_st   = WAIT_RD;
                    end
                end
            end
            WAIT_WR: if (addr_vld) begin
                wr_en  = 1'b1;
                nxt_st = IDLE;
            end
            WAIT_RD: if (addr_vld) begin
                rd_en  = 1'b1;
                nxt_st = LOAD;
            end
            LOAD: begin
                ld_obj      = 1'b1;         // obj_in valid the cycle after rd_en
                coeff_start = is_rot;
                nxt_st      = cmd.cen ? CENTROID : (is_rot ? COEFF_WAIT : ISSUE);
            end
            CENTROID: begin
                calc_cen = 1'b1;
                nxt_st   = ISSUE;
            end
            COEFF_WAIT: nxt_st = ISSUE;     // table output lands here
            ISSUE: begin
                issue  = 1'b1;
                nxt_st = PT_WAIT;
            end
            PT_WAIT: if (res_vld) begin
                ldback = 1'b1;
                nxt_st = last_pt ? WRITEBACK : ISSUE;
            end
            WRITEBACK: begin
                writeback = 1'b1;
                ref_addr  = 1'b1;
                nxt_st    = WAIT_WR;
            end
            default: nxt_st = IDLE;
        endcase
    end

    // slot number only while the object unit is being asked for it
    assign obj_num_out = (del_obj || ref_addr) ? (idle ? cmd_live.slot : cmd.slot) : '0;

endmodule

/* design/gmt_unit.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module gmt_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  gmt_pkg::gmt_req_t      req,
    output logic                   busy,
    output logic                   crt_obj,
    output logic                   del_obj,
    output logic                   ref_addr,
    output logic [`GMT_SLOT_W-1:0] obj_num_out,
    input  logic                   addr_vld,
    input  logic                   obj_mem_full,
    output logic                   rd_en,
    output logic                   wr_en,
    output gmt_pkg::gmt_obj_t      obj_out,
    input  gmt_pkg::gmt_obj_t      obj_in
);
    import gmt_pkg::*;

    gmt_cmd_t   cmd_live, cmd;
    gmt_point_t res, pt_out;
    logic       accept, ld_obj, calc_cen, issue, ldback, writeback;
    logic       coeff_start, res_vld;
    logic [1:0] point_idx, obj_type;

    gmt_cmd_decode gmt_cmd_decode_inst (
        .clk, .rst_n, .accept, .req, .cmd_live, .cmd
    );

    gmt_sequencer gmt_sequencer_inst (
        .clk, .rst_n, .go, .cmd_live, .cmd, .obj_type, .addr_vld, .obj_mem_full,
        .res_vld, .accept, .busy, .crt_obj, .del_obj, .ref_addr, .rd_en, .wr_en,
        .obj_num_out, .ld_obj, .calc_cen, .issue, .ldback, .writeback, .point_idx,
        .coeff_start
    );

    point_transform point_transform_inst (
        .clk, .rst_n, .issue, .coeff_start, .cmd, .pt_in(pt_out), .res_vld, .res
    );

    obj_point_store obj_point_store_inst (
        .clk,
        .ld_obj,
        .calc_cen,
        .ldback,
        .writeback,
        .crt_load (crt_obj),    // create image is taken straight from the request
        .cmd,
        .point_idx,
        .req_obj  (req.obj),
        .obj_in,
        .res,
        .pt_out,
        .obj_type,
        .obj_out
    );

endmodule

/* design/obj_point_store.sv */
`timescale 1ns/100ps

module obj_point_store (
    input  logic                clk,
    input  logic                ld_obj,
    input  logic                calc_cen,
    input  logic                ldback,
    input  logic                writeback,
    input  logic                crt_load,
    input  gmt_pkg::gmt_cmd_t   cmd,
    input  logic [1:0]          point_idx,
    input  gmt_pkg::gmt_obj_t   req_obj,
    input  gmt_pkg::gmt_obj_t   obj_in,
    input  gmt_pkg::gmt_point_t res,
    output gmt_pkg::gmt_point_t pt_out,
    output logic [1:0]          obj_type,
    output gmt_pkg::gmt_obj_t   obj_out
);
    import gmt_pkg::*;

    gmt_point_t [3:0]   pts;
    logic [7:0]         colour;
    gmt_point_t         cen;
    gmt_point_t         cen_calc;
    logic signed [17:0] sum2_x, sum2_y, sum4_x, sum4_y;

    // points above the shape's last vertex go out as zero
    function automatic gmt_obj_t pack_obj(logic [1:0] shape, logic [7:0] col,
                                          gmt_point_t [3:0] p, gmt_point_t add);
        gmt_obj_t o;
        o        = '0;
        o.shape  = shape;
        o.colour = col;
        for (int i = 0; i < 4; i++) begin
            if (i <= shape) begin
                o.pts[i].x = p[i].x + add.x;
                o.pts[i].y = p[i].y + add.y;
            end
        end
        return o;
    endfunction

    assign sum2_x = pts[0].x + pts[1].x;
    assign sum2_y = pts[0].y + pts[1].y;
    assign sum4_x = pts[0].x + pts[1].x + pts[2].x + pts[3].x;
    assign sum4_y = pts[0].y + pts[1].y + pts[2].y + pts[3].y;

    always_comb begin
        case (obj_type)
            2'd0:    cen_calc = pts[0];
            2'd1:    cen_calc = {sum2_y[16:1], sum2_x[16:1]};
            2'd3:    cen_calc = {sum4_y[17:2], sum4_x[17:2]};
            default: cen_calc = '0;    // triangle works about the origin
        endcase
    end

    assign pt_out = pts[point_idx];

    always_ff @(posedge clk) begin
        if (ld_obj) begin
            pts      <= obj_in.pts;
            colour   <= obj_in.colour;
            obj_type <= obj_in.shape;
        end else if (calc_cen) begin
            cen <= cen_calc;
            for (int i = 0; i < 4; i++) begin
                pts[i].x <= pts[i].x - cen_calc.x;
                pts[i].y <= pts[i].y - cen_calc.y;
            end
        end else if (ldback) begin
            // translate-one leaves every other point alone
            if (cmd.kind != K_TRANS_ONE || point_idx == cmd.pt_sel) begin
                pts[point_idx] <= res;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crt_load) begin
            obj_out <= pack_obj(req_obj.shape, req_obj.colour, req_obj.pts, '0);
        end else if (writeback) begin
            obj_out <= pack_obj(obj_type, colour, pts, cmd.cen ? cen : '0);
        end
    end

endmodule

/* design/point_transform.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module point_transform (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic                coeff_start,
    input  gmt_pkg::gmt_cmd_t   cmd,
    input  gmt_pkg::gmt_point_t pt_in,
    output logic                res_vld,
    output gmt_pkg::gmt_point_t res
);
    import gmt_pkg::*;

    logic [2*`GMT_COORD_W-1:0] cs;
    gmt_coeff_t         coeff_nxt;
    gmt_coeff_t         coeff;
    gmt_point_t         pt;
    logic signed [31:0] p11, p12, p21, p22;
    logic signed [31:0] sh_x, sh_y;
    logic [4:0]         shamt;
    logic               mul_vld, add_vld;

    rot_coeff_rom rot_coeff_rom_inst (
        .clk       (clk),
        .start     (coeff_start),
        .dir_right (cmd.kind == K_ROT_R),
        .step      (cmd.rot_step),
        .cs        (cs)
    );

    always_comb begin
        coeff_nxt = '0;
        shamt     = '0;
        case (cmd.kind)
            K_SCALE: begin
                coeff_nxt.c11 = 16'(cmd.scl_num);
                coeff_nxt.c22 = 16'(cmd.scl_num);
                shamt         = 5'(cmd.scl_shift);
            end
            K_ROT_L, K_ROT_R: begin
                coeff_nxt.c11 = cs[31:16];
                coeff_nxt.c12 = -cs[15:0];
                coeff_nxt.c21 = cs[15:0];
                coeff_nxt.c22 = cs[31:16];
                shamt         = `GMT_Q15;
            end
            default: begin   // translate: identity plus offset
                coeff_nxt.c11 = 16'sd1;
                coeff_nxt.c22 = 16'sd1;
                coeff_nxt.ox  = cmd.tx ? cmd.offset : '0;
                coeff_nxt.oy  = cmd.ty ? cmd.offset : '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_vld <= 1'b0;
            add_vld <= 1'b0;
            res_vld <= 1'b0;
        end else begin
            mul_vld <= issue;
            add_vld <= mul_vld;
            res_vld <= add_vld;
        end
    end

    assign sh_x = (p11 + p12) >>> shamt;
    assign sh_y = (p21 + p22) >>> shamt;

    always_ff @(posedge clk) begin
        if (issue) begin
            pt    <= pt_in;
            coeff <= coeff_nxt;
        end
        if (mul_vld) begin
            p11 <= pt.x * coeff.c11;
            p12 <= pt.y * coeff.c12;
            p21 <= pt.x * coeff.c21;
            p22 <= pt.y * coeff.c22;
        end
        if (add_vld) begin
            res.x <= sh_x[`GMT_COORD_W-1:0] + coeff.ox;
            res.y <= sh_y[`GMT_COORD_W-1:0] + coeff.oy;
        end
    end

endmodule

/* design/rot_coeff_rom.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module rot_coeff_rom (
    input  logic                       clk,
    input  logic                       start,
    input  logic                       dir_right,
    input  logic [2:0]                 step,
    output logic [2*`GMT_COORD_W-1:0] cs      // {C, S}
);
    logic signed [`GMT_COORD_W-1:0] c_val;
    logic signed [`GMT_COORD_W-1:0] s_val;

    always_comb begin
        case (step)
            3'd0:    {c_val, s_val} = {16'sd32767,  16'sd0};
            3'd1:    {c_val, s_val} = {16'sd23170,  16'sd23170};
            3'd2:    {c_val, s_val} = {16'sd0,      16'sd32767};
            3'd3:    {c_val, s_val} = {-16'sd23170, 16'sd23170};
            3'd4:    {c_val, s_val} = {-16'sd32767, 16'sd0};
            3'd5:    {c_val, s_val} = {-16'sd23170, -16'sd23170};
            3'd6:    {c_val, s_val} = {16'sd0,      -16'sd32767};
            default: {c_val, s_val} = {16'sd23170,  -16'sd23170};
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cs <= {c_val, dir_right ? -s_val : s_val};   // right turn flips sine
        end
    end

endmodule

/* dv/gmt_unit_asserts.sv */
`timescale 1ns/100ps

module gmt_unit_asserts (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic accept,
    input logic crt_obj,
    input logic del_obj,
    input logic ref_addr,
    input logic rd_en,
    input logic wr_en,
    input logic addr_vld
);
    int unsigned n_fail = 0;    // read by the testbench at the end of the run

    // video memory strobes only ride on the object unit's address strobe
    mem_strobe_on_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en || wr_en) |-> addr_vld)
    else begin
        n_fail++;
        $error("rd_en or wr_en high without addr_vld");
    end

    obj_unit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({crt_obj, del_obj, ref_addr}))
    else begin
        n_fail++;
        $error("more than one of crt_obj, del_obj and ref_addr high");
    end

    // strobes belong to a running command or to the cycle that accepts one
    strobe_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (crt_obj || del_obj || ref_addr || rd_en || wr_en) |-> (busy || accept))
    else begin
        n_fail++;
        $error("strobe high while the unit is not busy");
    end

endmodule

bind gmt_unit gmt_unit_asserts gmt_unit_asserts_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .accept   (accept),
    .crt_obj  (crt_obj),
    .del_obj  (del_obj),
    .ref_addr (ref_addr),
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .addr_vld (addr_vld)
);

/* dv/gmt_unit_tb.sv */
`timescale 1ns/100ps
`include "gmt_consts.svh"

module gmt_unit_tb;
    import gmt_pkg::*;

    localparam int RST_CYCLES  = 4;
    localparam int N_CMDS      = 66;     // commands issued by the stimulus below
    localparam int CYC_PER_CMD = 200;
    localparam int COS_TAB [8] = '{32767, 23170, 0, -23170, -32767, -23170, 0, 23170};
    localparam int SIN_TAB [8] = '{0, 23170, 32767, 23170, 0, -23170, -32767, -23170};

    logic                   clk          = 1'b0;
    logic                   rst_n        = 1'b0;
    logic                   go           = 1'b0;
    gmt_req_t               req          = '0;
    logic                   addr_vld     = 1'b0;
    logic                   obj_mem_full = 1'b0;
    gmt_obj_t               obj_in       = '0;
    logic                   busy, crt_obj, del_obj, ref_addr, rd_en, wr_en;
    logic [`GMT_SLOT_W-1:0] obj_num_out;
    gmt_obj_t               obj_out;

    gmt_obj_t               mem [32];      // video memory behind the DUT
    gmt_obj_t               ref_mem [32];  // expected image
    logic [`GMT_SLOT_W-1:0] new_slot = '0; // slot handed out on create
    logic [`GMT_SLOT_W-1:0] tgt;
    logic                   pend;
    int unsigned            wait_cnt;
    int                     n_crt = 0, n_del = 0, n_ref = 0, n_wr = 0;
    logic [`GMT_SLOT_W-1:0] del_slot = '0;
    int                     n_chk = 0, n_err = 0;
    string                  name_q [$];
    int                     slot_q [$];
    gmt_obj_t               exp_q [$];

    gmt_unit gmt_unit_inst (
        .clk, .rst_n, .go, .req, .busy, .crt_obj, .del_obj, .ref_addr, .obj_num_out,
        .addr_vld, .obj_mem_full, .rd_en, .wr_en, .obj_out, .obj_in
    );

    always #2 clk = ~clk;

    // object unit answers after 0..5 idle cycles and memory follows the granted slot
    always @(posedge clk or negedge rst_n) begin : obj_unit_model
        int unsigned dly;
        if (!rst_n) begin
            addr_vld <= 1'b0;
            pend     <= 1'b0;
            wait_cnt <= 0;
            tgt      <= '0;
            obj_in   <= '0;
            for (int i = 0; i < 32; i++) begin
                mem[i] <= fill_obj(i);
            end
        end else begin
            addr_vld <= 1'b0;
            if (crt_obj || ref_addr) begin
                dly = $urandom % 6;
                tgt <= crt_obj ? new_slot : obj_num_out;
                if (dly == 0) begin
                    addr_vld <= 1'b1;     // answer right in the next cycle
                end else begin
                    pend     <= 1'b1;
                    wait_cnt <= dly - 1;
                end
            end else if (pend) begin
                if (wait_cnt == 0) begin
                    addr_vld <= 1'b1;
                    pend     <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
            if (rd_en) obj_in <= mem[tgt];
            if (wr_en) mem[tgt] <= obj_out;
            if (del_obj) mem[obj_num_out] <= '0;
        end
    end

    always @(posedge clk) begin : strobe_count
        if (crt_obj) n_crt++;
        if (ref_addr) n_ref++;
        if (wr_en) n_wr++;
        if (del_obj) begin
            n_del++;
            del_slot = obj_num_out;
        end
    end

    function automatic int wrap16(input int v);
        logic signed [15:0] t;
        t = v[15:0];
        return t;
    endfunction

    function automatic logic [15:0] rnd_coord(input int lim);
        int v;
        v = int'($urandom % (2 * lim + 1)) - lim;
        return 16'(v);
    endfunction

    function automatic gmt_obj_t fill_obj(input int slot);
        gmt_obj_t o;
        o        = '0;
        o.shape  = slot[1:0];
        o.colour = 8'(slot * 29 + 3);
        for (int k = 0; k < 4; k++) begin
            o.pts[k].x = 16'(slot * 131 + k);
            o.pts[k].y = 16'(-slot * 97 - k);
        end
        return o;
    endfunction

    function automatic gmt_obj_t rand_obj(input logic [1:0] shape);
        gmt_obj_t o;
        o.shape  = shape;
        o.pad    = 6'($urandom);    // image keeps the pad at zero
        o.colour = 8'($urandom);
        for (int k = 0; k < 4; k++) begin
            o.pts[k].x = rnd_coord(1000);
            o.pts[k].y = rnd_coord(1000);
        end
        return o;
    endfunction

    // expected memory image after one command
    function automatic gmt_obj_t ref_transform(input gmt_obj_t o, input logic [3:0] op,
                                               input logic [3:0] code,
                                               input logic signed [15:0] off);
        gmt_obj_t r;
        bit       rot, about_cen;
        int       px [4];
        int       py [4];
        int       cx, cy, x, y, nx, ny, c, s, num, sh;
        r         = '0;
        r.shape   = o.shape;
        r.colour  = o.colour;
        rot       = (op == `GMT_OP_ROT_L) || (op == `GMT_OP_ROT_R);
        about_cen = (op == `GMT_OP_SCALE) || (rot && code[3]);
        for (int k = 0; k < 4; k++) begin
            px[k] = $signed(o.pts[k].x);
            py[k] = $signed(o.pts[k].y);
        end
        cx = 0;
        cy = 0;
        if (about_cen && o.shape == 2'd0) begin
            cx = px[0];
            cy = py[0];
        end else if (about_cen && o.shape == 2'd1) begin
            cx = (px[0] + px[1]) >>> 1;
            cy = (py[0] + py[1]) >>> 1;
        end else if (about_cen && o.shape == 2'd3) begin
            cx = (px[0] + px[1] + px[2] + px[3]) >>> 2;
            cy = (py[0] + py[1] + py[2] + py[3]) >>> 2;
        end
        num = (code[1:0] == 2'd0) ? 1 : ((code[1:0] == 2'd3) ? 2 : 3);
        sh  = (code[1:0] == 2'd3) ? 0 : ((code[1:0] == 2'd1) ? 2 : 1);
        c   = COS_TAB[code[2:0]];
        s   = (op == `GMT_OP_ROT_R) ? -SIN_TAB[code[2:0]] : SIN_TAB[code[2:0]];
        for (int k = 0; k < 4; k++) begin
            if (k <= o.shape) begin
                x  = wrap16(px[k] - cx);
                y  = wrap16(py[k] - cy);
                nx = x;
                ny = y;
                if (op == `GMT_OP_TRANS_ALL || (op == `GMT_OP_TRANS_ONE && k == code[3:2])) begin
                    nx = code[0] ? x + off : x;
                    ny = code[1] ? y + off : y;
                end else if (op == `GMT_OP_SCALE) begin
                    nx = (x * num) >>> sh;
                    ny = (y * num) >>> sh;
                end else if (rot) begin
                    nx = (x * c - y * s) >>> `GMT_Q15;
                    ny = (x * s + y * c) >>> `GMT_Q15;
                end
                r.pts[k].x = 16'(nx + cx);
                r.pts[k].y = 16'(ny + cy);
            end
        end
        return r;
    endfunction

    task automatic expect_equal(input string name, input logic [143:0] exp,
                                input logic [143:0] act);
        n_chk++;
        assert (act === exp) else begin
            n_err++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic push_check(input string name, input int slot);
        name_q.push_back(name);
        slot_q.push_back(slot);
        exp_q.push_back(ref_mem[slot]);   // pushed last since the compare process waits on it
    endtask

    // one request and a wait until the unit is idle again
    task automatic run_cmd(input logic [3:0] op, input logic [3:0] code, input logic [4:0] slot,
                           input gmt_obj_t obj, input bit poke, output bit acc_busy);
        gmt_req_t r;
        r.op   = op;
        r.code = code;
        r.slot = slot;
        r.obj  = obj;
        @(posedge clk);
        go  <= 1'b1;
        req <= r;
        @(posedge clk);
        acc_busy = busy;
        go       <= 1'b0;
        if (poke) begin
            @(posedge clk);
            go       <= 1'b1;         // delete of slot 0 while busy
            req.op   <= `GMT_OP_DELETE;
            req.slot <= 5'd0;
            @(posedge clk);
            go <= 1'b0;
        end
        do @(posedge clk); while (busy);
    endtask

    task automatic create_obj(input logic [4:0] slot, input logic [1:0] shape);
        gmt_obj_t obj;
        bit       acc_busy;
        int       n_wr0;
        obj      = rand_obj(shape);
        new_slot = slot;
        n_wr0    = n_wr;
        run_cmd(`GMT_OP_CREATE, 4'h0, slot, obj, 1'b0, acc_busy);
        expect_equal("create wr_en count", n_wr0 + 1, n_wr);
        ref_mem[slot] = ref_transform(obj, `GMT_OP_CREATE, 4'h0, '0);
        push_check($sformatf("create type %0d", shape), slot);
    endtask

    task automatic transform_obj(input string name, input logic [3:0] op, input logic [3:0] code,
                                 input logic [4:0] slot, input bit poke);
        gmt_obj_t           obj;
        logic signed [15:0] off;
        bit                 acc_busy;
        int                 n_del0;
        off          = rnd_coord(100);
        obj          = '0;
        obj.pts[0].x = off;           // translate amount
        n_del0       = n_del;
        run_cmd(op, code, slot, obj, poke, acc_busy);
        expect_equal({name, " busy"}, 1, acc_busy);
        expect_equal({name, " del_obj count"}, n_del0, n_del);
        ref_mem[slot] = ref_transform(ref_mem[slot], op, code, off);
        push_check(name, slot);
    endtask

    task automatic drop_cmd(input logic [3:0] op);
        bit acc_busy;
        int n_strobe;
        n_strobe = n_crt + n_del + n_ref + n_wr;
        run_cmd(op, 4'($urandom), 5'd2, rand_obj(2'd3), 1'b0, acc_busy);
        expect_equal($sformatf("opcode %0d busy", op), 0, acc_busy);
        expect_equal($sformatf("opcode %0d strobes", op), n_strobe,
                     n_crt + n_del + n_ref + n_wr);
    endtask

    initial begin : stimulus
        bit acc_busy;
        int n_del0, n_strobe, n_sva;
        void'($urandom(32'h6c0b_8bda));
        for (int i = 0; i < 32; i++) begin
            ref_mem[i] = fill_obj(i);
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int s = 0; s < 8; s++) begin
            create_obj(5'(s), 2'(s));
        end
        for (int f = 0; f < 4; f++) begin
            transform_obj($sformatf("trans_one flags %0d", f), `GMT_OP_TRANS_ONE,
                          {2'($urandom), 2'(f)}, 5'd3, 1'b0);
            transform_obj($sformatf("trans_all flags %0d", f), `GMT_OP_TRANS_ALL,
                          {2'b00, 2'(f)}, 5'(4 + f), 1'b0);
        end
        for (int r = 0; r < 4; r++) begin
            for (int t = 0; t < 3; t++) begin
                transform_obj($sformatf("scale ratio %0d type %0d", r, t), `GMT_OP_SCALE,
                              4'(r), 5'(t == 2 ? 3 : t), 1'b0);
            end
        end
        for (int d = 0; d < 2; d++) begin
            for (int k = 0; k < 8; k++) begin
                for (int c = 0; c < 2; c++) begin
                    transform_obj($sformatf("rot_%s step %0d cen %0d", d ? "r" : "l", k, c),
                                  d ? `GMT_OP_ROT_R : `GMT_OP_ROT_L, {1'(c), 3'(k)},
                                  5'(k), 1'b0);
                end
            end
        end
        transform_obj("trans_all with go while busy", `GMT_OP_TRANS_ALL, 4'h3, 5'd1, 1'b1);
        drop_cmd(4'h2);
        drop_cmd(4'h8);
        drop_cmd(4'hf);

        n_del0 = n_del;
        run_cmd(`GMT_OP_DELETE, 4'h0, 5'd7, '0, 1'b0, acc_busy);
        expect_equal("delete busy", 1, acc_busy);
        expect_equal("delete del_obj count", n_del0 + 1, n_del);
        expect_equal("delete slot", 7, del_slot);
        ref_mem[7] = '0;
        push_check("delete", 7);

        @(posedge clk);
        obj_mem_full <= 1'b1;
        new_slot     = 5'd8;
        n_strobe     = n_crt + n_wr;
        run_cmd(`GMT_OP_CREATE, 4'h0, 5'd8, rand_obj(2'd2), 1'b0, acc_busy);
        expect_equal("create when full busy", 1, acc_busy);
        expect_equal("create when full strobes", n_strobe, n_crt + n_wr);
        obj_mem_full <= 1'b0;

        for (int s = 0; s < 32; s++) begin
            push_check("final image", s);
        end
        wait (exp_q.size() == 0);
        @(posedge clk);
        n_sva = gmt_unit_inst.gmt_unit_asserts_inst.n_fail;
        $display("checks %0d, value errors %0d, assertion failures %0d", n_chk, n_err, n_sva);
        if (n_err == 0 && n_sva == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : compare
        string    name;
        int       slot;
        gmt_obj_t exp_obj;
        forever begin
            wait (exp_q.size() != 0);
            name    = name_q.pop_front();
            slot    = slot_q.pop_front();
            exp_obj = exp_q.pop_front();
            expect_equal($sformatf("%s slot %0d", name, slot), exp_obj, mem[slot]);
        end
    end

    initial begin : watchdog
        repeat (RST_CYCLES + N_CMDS * CYC_PER_CMD) @(posedge clk);
        $display("timeout, the command sequence did not finish in %0d cycles",
                 RST_CYCLES + N_CMDS * CYC_PER_CMD);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/gmt_pkg.sv
design/gmt_cmd_decode.sv
design/gmt_sequencer.sv
design/rot_coeff_rom.sv
design/point_transform.sv
design/obj_point_store.sv
design/gmt_unit.sv
dv/gmt_unit_asserts.sv
dv/gmt_unit_tb.sv
